// ==== hist_pkg.sv ====
package hist_pkg;

    // default sizes, overridable from the top level
    localparam int PIXEL_NUM_DEF = 4;
    localparam int DATA_NUM_DEF  = 3;
    localparam int ACQ_NUM_DEF   = 5;
    localparam int TS_W_DEF      = 8;
    localparam int COARSE_W_DEF  = 4;
    localparam int FINE_W_DEF    = 4;
    localparam int COUNT_W_DEF   = 5;

    // pixel index width, at least one bit
    localparam int PIXEL_W_DEF = (PIXEL_NUM_DEF > 1) ? $clog2(PIXEL_NUM_DEF) : 1;

    // photon arrival time
    typedef logic [TS_W_DEF-1:0] ts_t;

    // upper bits of a time stamp
    typedef logic [COARSE_W_DEF-1:0] coarse_bin_t;

    // lower bits of a time stamp
    typedef logic [FINE_W_DEF-1:0] fine_bin_t;

    typedef logic [PIXEL_W_DEF-1:0] pixel_t;

    // saturating bin count
    typedef logic [COUNT_W_DEF-1:0] count_t;

    // sequencer states
    // COLLECT takes hits, SETTLE waits for the last peak update,
    // DRAIN holds input off while results go out
    typedef enum logic [1:0] {
        COLLECT,
        SETTLE,
        DRAIN
    } seq_state_t;

endpackage

// ==== acq_sequencer.sv ====
`timescale 1ns/10ps

module acq_sequencer import hist_pkg::*; #(
    parameter int PIXEL_NUM = PIXEL_NUM_DEF,
    parameter int DATA_NUM  = DATA_NUM_DEF,
    parameter int ACQ_NUM   = ACQ_NUM_DEF
) (
    input  logic   clk,
    input  logic   combin_res,
    input  logic   ts_valid,
    input  logic   drained,
    output logic   ts_ready,
    output logic   hit_valid,
    output pixel_t pixel,
    output logic   frame_done
);

    localparam int HIT_W = (DATA_NUM > 1) ? $clog2(DATA_NUM) : 1;
    localparam int ACQ_W = (ACQ_NUM > 1) ? $clog2(ACQ_NUM) : 1;

    seq_state_t       state;
    logic [HIT_W-1:0] hit_cnt;
    logic [ACQ_W-1:0] acq_cnt;
    logic             settle_cnt;
    logic             hit_wrap;
    logic             pixel_wrap;
    logic             acq_wrap;
    logic             last_hit;

    // input only open while collecting
    assign ts_ready  = (state == COLLECT);
    assign hit_valid = ts_valid && ts_ready;

    // wrap points of the three nested counters
    assign hit_wrap   = (hit_cnt == HIT_W'(DATA_NUM - 1));
    assign pixel_wrap = (pixel == pixel_t'(PIXEL_NUM - 1));
    assign acq_wrap   = (acq_cnt == ACQ_W'(ACQ_NUM - 1));
    // final hit of the frame
    assign last_hit   = hit_wrap && pixel_wrap && acq_wrap;

    // hits per pixel, then pixels, then acquisitions
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hit_cnt <= '0;
            pixel   <= '0;
            acq_cnt <= '0;
        end else if (hit_valid) begin
            if (hit_wrap) begin
                hit_cnt <= '0;
                if (pixel_wrap) begin
                    pixel <= '0;
                    // all counters back at zero after the last hit
                    acq_cnt <= acq_wrap ? '0 : acq_cnt + 1'b1;
                end else begin
                    pixel <= pixel + 1'b1;
                end
            end else begin
                hit_cnt <= hit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state      <= COLLECT;
            settle_cnt <= 1'b0;
        end else begin
            case (state)
                COLLECT: begin
                    if (hit_valid && last_hit) begin
                        state      <= SETTLE;
                        settle_cnt <= 1'b0;
                    end
                end
                SETTLE: begin
                    // two cycles, peak update of the last hit lands meanwhile
                    if (settle_cnt) begin
                        state <= DRAIN;
                    end else begin
                        settle_cnt <= 1'b1;
                    end
                end
                DRAIN: begin
                    // last result taken, histograms cleared on the same edge
                    if (drained) begin
                        state <= COLLECT;
                    end
                end
                default: begin
                    state <= COLLECT;
                end
            endcase
        end
    end

    // pulse in the first DRAIN cycle
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            frame_done <= 1'b0;
        end else begin
            frame_done <= (state == SETTLE) && settle_cnt;
        end
    end

endmodule

// ==== hist_builder.sv ====
`timescale 1ns/10ps

module hist_builder import hist_pkg::*; #(
    parameter int BIN_W     = COARSE_W_DEF,
    parameter int PIXEL_NUM = PIXEL_NUM_DEF,
    parameter int COUNT_W   = COUNT_W_DEF
) (
    input  logic             clk,
    input  logic             combin_res,
    input  logic             hit_valid,
    input  pixel_t           pixel,
    input  logic [BIN_W-1:0] hit_bin,
    input  logic             clear,
    input  pixel_t           rd_pixel,
    output logic [BIN_W-1:0] peak_bin,
    output count_t           peak_count
);

    localparam int BIN_NUM = 1 << BIN_W;

    // count memory, meaningful only where the valid bit is set
    logic [COUNT_W-1:0] cnt_mem [PIXEL_NUM][BIN_NUM];
    // one valid bit per bin, per pixel
    logic [BIN_NUM-1:0] bin_vld [PIXEL_NUM];

    // running peak per pixel
    logic [COUNT_W-1:0] peak_cnt_mem [PIXEL_NUM];
    logic [BIN_W-1:0]   peak_bin_mem [PIXEL_NUM];

    logic [COUNT_W-1:0] cur_count;
    logic [COUNT_W-1:0] new_count;

    // hit registered for the peak compare
    logic               upd_valid;
    pixel_t             upd_pixel;
    logic [BIN_W-1:0]   upd_bin;
    logic [COUNT_W-1:0] upd_count;

    assign cur_count = cnt_mem[pixel][hit_bin];

    // invalid entry restarts at one
    // valid entry counts up and sticks at the top
    always_comb begin
        if (!bin_vld[pixel][hit_bin]) begin
            new_count = COUNT_W'(1);
        end else if (cur_count == {COUNT_W{1'b1}}) begin
            new_count = cur_count;
        end else begin
            new_count = cur_count + 1'b1;
        end
    end

    // bin counts, written on the accepting edge
    always_ff @(posedge clk) begin
        if (hit_valid) begin
            cnt_mem[pixel][hit_bin] <= new_count;
        end
    end

    // new count and its address, for the next cycle
    always_ff @(posedge clk) begin
        upd_pixel <= pixel;
        upd_bin   <= hit_bin;
        upd_count <= new_count;
    end

    // valid bits, all dropped at once on clear
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                bin_vld[p] <= '0;
            end
            upd_valid <= 1'b0;
        end else if (clear) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                bin_vld[p] <= '0;
            end
            upd_valid <= 1'b0;
        end else begin
            if (hit_valid) begin
                bin_vld[pixel][hit_bin] <= 1'b1;
            end
            upd_valid <= hit_valid;
        end
    end

    // peak moves only on a strictly greater count
    // so on a tie the earlier bin stays
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                peak_cnt_mem[p] <= '0;
                peak_bin_mem[p] <= '0;
            end
        end else if (clear) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                peak_cnt_mem[p] <= '0;
                peak_bin_mem[p] <= '0;
            end
        end else if (upd_valid && (upd_count > peak_cnt_mem[upd_pixel])) begin
            peak_cnt_mem[upd_pixel] <= upd_count;
            peak_bin_mem[upd_pixel] <= upd_bin;
        end
    end

    // read port for the combiner, no delay
    assign peak_bin   = peak_bin_mem[rd_pixel];
    assign peak_count = peak_cnt_mem[rd_pixel];

endmodule

// ==== peak_combiner.sv ====
`timescale 1ns/10ps

module peak_combiner import hist_pkg::*; #(
    parameter int PIXEL_NUM = PIXEL_NUM_DEF
) (
    input  logic        clk,
    input  logic        combin_res,
    input  logic        frame_done,
    input  logic        res_ready,
    input  coarse_bin_t coarse_peak,
    input  count_t      coarse_count,
    input  fine_bin_t   fine_peak,
    input  count_t      fine_count,
    output pixel_t      rd_pixel,
    output logic        res_valid,
    output pixel_t      res_pixel,
    output coarse_bin_t res_coarse,
    output fine_bin_t   res_fine,
    output count_t      res_coarse_count,
    output count_t      res_fine_count,
    output logic        drained
);

    logic   res_take;
    logic   last_out;
    logic   load;
    pixel_t next_pixel;

    // output handshake
    assign res_take = res_valid && res_ready;
    // result on the port is the final pixel
    assign last_out = (res_pixel == pixel_t'(PIXEL_NUM - 1));
    // end of frame, clears both histograms
    assign drained  = res_take && last_out;

    // rd_pixel points at the pixel to load next
    assign next_pixel = (rd_pixel == pixel_t'(PIXEL_NUM - 1)) ? '0 : rd_pixel + 1'b1;

    // pixel 0 on frame_done, then one more per taken result
    assign load = frame_done || (res_take && !last_out);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            res_valid <= 1'b0;
            rd_pixel  <= '0;
        end else if (load) begin
            res_valid <= 1'b1;
            // wraps to 0 after loading the last pixel
            rd_pixel  <= next_pixel;
        end else if (res_take) begin
            // final result gone, idle until the next frame
            res_valid <= 1'b0;
        end
    end

    // result fields held while res_ready is low
    always_ff @(posedge clk) begin
        if (load) begin
            res_pixel        <= rd_pixel;
            res_coarse       <= coarse_peak;
            res_fine         <= fine_peak;
            res_coarse_count <= coarse_count;
            res_fine_count   <= fine_count;
        end
    end

endmodule

// ==== hist_peak_top.sv ====
`timescale 1ns/10ps

module hist_peak_top import hist_pkg::*; #(
    parameter int PIXEL_NUM = PIXEL_NUM_DEF,
    parameter int DATA_NUM  = DATA_NUM_DEF,
    parameter int ACQ_NUM   = ACQ_NUM_DEF,
    parameter int TS_W      = TS_W_DEF,
    parameter int COARSE_W  = COARSE_W_DEF,
    parameter int FINE_W    = FINE_W_DEF,
    parameter int COUNT_W   = COUNT_W_DEF
) (
    input  logic        clk,
    input  logic        combin_res,
    input  logic        ts_valid,
    input  ts_t         ts_data,
    output logic        ts_ready,
    output logic        res_valid,
    input  logic        res_ready,
    output pixel_t      res_pixel,
    output coarse_bin_t res_coarse,
    output fine_bin_t   res_fine,
    output count_t      res_coarse_count,
    output count_t      res_fine_count
);

    logic        hit_valid;
    pixel_t      pixel;
    logic        frame_done;
    logic        drained;
    pixel_t      rd_pixel;
    coarse_bin_t coarse_hit;
    fine_bin_t   fine_hit;
    coarse_bin_t coarse_peak;
    fine_bin_t   fine_peak;
    count_t      coarse_count;
    count_t      fine_count;

    // coarse field from the top bits, fine from the bottom
    assign coarse_hit = ts_data[TS_W-1 -: COARSE_W];
    assign fine_hit   = ts_data[FINE_W-1:0];

    acq_sequencer #(
        .PIXEL_NUM (PIXEL_NUM),
        .DATA_NUM  (DATA_NUM),
        .ACQ_NUM   (ACQ_NUM)
    ) sequencer (
        .clk        (clk),
        .combin_res (combin_res),
        .ts_valid   (ts_valid),
        .drained    (drained),
        .ts_ready   (ts_ready),
        .hit_valid  (hit_valid),
        .pixel      (pixel),
        .frame_done (frame_done)
    );

    hist_builder #(
        .BIN_W     (COARSE_W),
        .PIXEL_NUM (PIXEL_NUM),
        .COUNT_W   (COUNT_W)
    ) coarse_builder (
        .clk        (clk),
        .combin_res (combin_res),
        .hit_valid  (hit_valid),
        .pixel      (pixel),
        .hit_bin    (coarse_hit),
        .clear      (drained),
        .rd_pixel   (rd_pixel),
        .peak_bin   (coarse_peak),
        .peak_count (coarse_count)
    );

    hist_builder #(
        .BIN_W     (FINE_W),
        .PIXEL_NUM (PIXEL_NUM),
        .COUNT_W   (COUNT_W)
    ) fine_builder (
        .clk        (clk),
        .combin_res (combin_res),
        .hit_valid  (hit_valid),
        .pixel      (pixel),
        .hit_bin    (fine_hit),
        .clear      (drained),
        .rd_pixel   (rd_pixel),
        .peak_bin   (fine_peak),
        .peak_count (fine_count)
    );

    peak_combiner #(
        .PIXEL_NUM (PIXEL_NUM)
    ) combiner (
        .clk              (clk),
        .combin_res       (combin_res),
        .frame_done       (frame_done),
        .res_ready        (res_ready),
        .coarse_peak      (coarse_peak),
        .coarse_count     (coarse_count),
        .fine_peak        (fine_peak),
        .fine_count       (fine_count),
        .rd_pixel         (rd_pixel),
        .res_valid        (res_valid),
        .res_pixel        (res_pixel),
        .res_coarse       (res_coarse),
        .res_fine         (res_fine),
        .res_coarse_count (res_coarse_count),
        .res_fine_count   (res_fine_count),
        .drained          (drained)
    );

endmodule

// ==== tb_hist_peak.sv ====
`timescale 1ns/10ps

module tb_hist_peak import hist_pkg::*; ();

    localparam int PIXEL_NUM  = PIXEL_NUM_DEF;
    localparam int DATA_NUM   = DATA_NUM_DEF;
    localparam int ACQ_NUM    = ACQ_NUM_DEF;
    localparam int TS_W       = TS_W_DEF;
    localparam int COARSE_W   = COARSE_W_DEF;
    localparam int FINE_W     = FINE_W_DEF;
    localparam int COUNT_W    = COUNT_W_DEF;
    localparam int C_BINS     = 1 << COARSE_W;
    localparam int F_BINS     = 1 << FINE_W;
    localparam int CNT_MAX    = (1 << COUNT_W) - 1;
    localparam int FRAME_HITS = PIXEL_NUM * DATA_NUM * ACQ_NUM;
    // cycles per hit and per result, transfer cycle included
    localparam int MAX_GAP    = 4;
    localparam int MAX_STALL  = 5;
    localparam int FRAMES     = 10;
    localparam int FRAME_BOUND = FRAME_HITS * MAX_GAP + PIXEL_NUM * MAX_STALL + 10;
    localparam int CYCLE_LIMIT = 2 * FRAMES * FRAME_BOUND;
    // stamp patterns
    localparam int KIND_RANDOM = 0;
    localparam int KIND_TIE    = 1;
    localparam int KIND_FIXED  = 2;

    logic        clk;
    logic        combin_res;
    logic        ts_valid;
    ts_t         ts_data;
    logic        ts_ready;
    logic        res_valid;
    logic        res_ready;
    pixel_t      res_pixel;
    coarse_bin_t res_coarse;
    fine_bin_t   res_fine;
    count_t      res_coarse_count;
    count_t      res_fine_count;

    integer seed;
    int     cycles = 0;
    int     err_cnt = 0;
    int     check_cnt = 0;
    int     test_cnt = 0;
    int     test_fail = 0;
    int     err_base;
    int     res_base;
    int     results_seen = 0;
    bit     tie_frame = 1'b0;

    // reference model state
    int c_cnt [PIXEL_NUM][C_BINS];
    int f_cnt [PIXEL_NUM][F_BINS];
    int c_pk_cnt [PIXEL_NUM];
    int c_pk_bin [PIXEL_NUM];
    int f_pk_cnt [PIXEL_NUM];
    int f_pk_bin [PIXEL_NUM];
    int hit_total;
    int res_idx;
    bit pending;
    bit lat_armed;
    int lat;

    hist_peak_top #(
        .PIXEL_NUM (PIXEL_NUM),
        .DATA_NUM  (DATA_NUM),
        .ACQ_NUM   (ACQ_NUM),
        .TS_W      (TS_W),
        .COARSE_W  (COARSE_W),
        .FINE_W    (FINE_W),
        .COUNT_W   (COUNT_W)
    ) dut0 (
        .clk              (clk),
        .combin_res       (combin_res),
        .ts_valid         (ts_valid),
        .ts_data          (ts_data),
        .ts_ready         (ts_ready),
        .res_valid        (res_valid),
        .res_ready        (res_ready),
        .res_pixel        (res_pixel),
        .res_coarse       (res_coarse),
        .res_fine         (res_fine),
        .res_coarse_count (res_coarse_count),
        .res_fine_count   (res_fine_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_true(input bit cond, input string what);
        check_cnt++;
        assert (cond) else begin
            $display("error at %0t: %s", $time, what);
            err_cnt++;
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_cnt++;
        assert (exp === act) else begin
            $display("mismatch %s: expected %0h, got %0h at %0t", name, exp, act, $time);
            err_cnt++;
        end
    endtask

    function automatic int rand_below(input int n);
        if (n <= 1) begin
            return 0;
        end
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic model_clear();
        for (int p = 0; p < PIXEL_NUM; p++) begin
            for (int b = 0; b < C_BINS; b++) begin
                c_cnt[p][b] = 0;
            end
            for (int b = 0; b < F_BINS; b++) begin
                f_cnt[p][b] = 0;
            end
            c_pk_cnt[p] = 0;
            c_pk_bin[p] = 0;
            f_pk_cnt[p] = 0;
            f_pk_bin[p] = 0;
        end
        hit_total = 0;
        res_idx   = 0;
        pending   = 1'b0;
        lat_armed = 1'b0;
    endtask

    // one accepted stamp, pixel follows from the hit order
    task automatic model_hit(input ts_t stamp);
        int p;
        int cb;
        int fb;
        p  = (hit_total / DATA_NUM) % PIXEL_NUM;
        cb = stamp[TS_W-1 -: COARSE_W];
        fb = stamp[FINE_W-1:0];
        if (c_cnt[p][cb] < CNT_MAX) c_cnt[p][cb]++;
        if (f_cnt[p][fb] < CNT_MAX) f_cnt[p][fb]++;
        // strictly greater only, earlier bin keeps a tie
        if (c_cnt[p][cb] > c_pk_cnt[p]) begin
            c_pk_cnt[p] = c_cnt[p][cb];
            c_pk_bin[p] = cb;
        end
        if (f_cnt[p][fb] > f_pk_cnt[p]) begin
            f_pk_cnt[p] = f_cnt[p][fb];
            f_pk_bin[p] = fb;
        end
        hit_total++;
        if (hit_total == FRAME_HITS) begin
            pending   = 1'b1;
            lat_armed = 1'b1;
            lat       = 0;
        end
    endtask

    task automatic check_result();
        check_true(res_pixel == pixel_t'(res_idx),
            $sformatf("result for pixel %0d arrived while pixel %0d was due", res_pixel, res_idx));
        check_val("res_coarse", c_pk_bin[res_idx], res_coarse);
        check_val("res_fine", f_pk_bin[res_idx], res_fine);
        check_val("res_coarse_count", c_pk_cnt[res_idx], res_coarse_count);
        check_val("res_fine_count", f_pk_cnt[res_idx], res_fine_count);
        // tie frame, bin 2p+2 reaches the shared count first
        if (tie_frame) begin
            check_val("res_coarse", 2 * res_idx + 2, res_coarse);
            check_val("res_fine", 2 * res_idx + 2, res_fine);
        end
        results_seen++;
        res_idx++;
        if (res_idx == PIXEL_NUM) model_clear();
    endtask

    // mid-cycle sampling, values hold until the next rising edge
    always @(negedge clk) begin
        if (combin_res) begin
            if (lat_armed) begin
                lat++;
                if (res_valid || lat >= 4) begin
                    check_true(res_valid && lat == 4, $sformatf(
                        "first result not exactly 4 cycles after the last hit (cycle %0d, res_valid %0b)",
                        lat, res_valid));
                    lat_armed = 1'b0;
                end
            end
            check_true(!(pending && ts_ready), "ts_ready high while frame results are pending");
            if (res_valid && res_ready) begin
                if (pending) check_result();
                else check_true(1'b0, "result handed out with no frame pending");
            end
            if (ts_valid && ts_ready) model_hit(ts_data);
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic ts_t make_stamp(input int kind, input int p, input int k);
        int b;
        case (kind)
            KIND_TIE: begin
                // bin 2p+1 seen first, bin 2p+2 reaches seven first
                if (k == 0 || (k >= 8 && k <= 13)) b = 2 * p + 1;
                else if (k <= 7) b = 2 * p + 2;
                else b = C_BINS - 1;
                return {coarse_bin_t'(b), fine_bin_t'(b)};
            end
            KIND_FIXED: return {coarse_bin_t'(p + 5), fine_bin_t'(10 - p)};
            default: return ts_t'($random(seed));
        endcase
    endfunction

    task automatic send_stamp(input ts_t stamp, input int max_gap);
        int gap;
        bit taken;
        gap = rand_below(max_gap);
        repeat (gap) next_cycle();
        ts_valid = 1'b1;
        ts_data  = stamp;
        taken    = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = ts_ready;
            next_cycle();
        end
        ts_valid = 1'b0;
    endtask

    // frame order is acquisition, then pixel, then hit
    task automatic send_acqs(input int kind, input int n_acq, input int max_gap);
        for (int a = 0; a < n_acq; a++) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                for (int h = 0; h < DATA_NUM; h++) begin
                    send_stamp(make_stamp(kind, p, a * DATA_NUM + h), max_gap);
                end
            end
        end
    endtask

    task automatic take_results(input int n, input int max_stall);
        int stall;
        bit took;
        for (int i = 0; i < n; i++) begin
            stall = rand_below(max_stall);
            if (stall > 0) begin
                res_ready = 1'b0;
                repeat (stall) next_cycle();
            end
            res_ready = 1'b1;
            took = 1'b0;
            while (!took) begin
                @(negedge clk);
                took = res_valid;
                next_cycle();
            end
        end
        res_ready = 1'b0;
    endtask

    task automatic run_frame(input int kind, input int max_gap, input int max_stall);
        fork
            send_acqs(kind, ACQ_NUM, max_gap);
            take_results(PIXEL_NUM, max_stall);
        join
    endtask

    task automatic apply_reset();
        combin_res = 1'b0;
        ts_valid   = 1'b0;
        res_ready  = 1'b0;
        model_clear();
        repeat (2) next_cycle();
        combin_res = 1'b1;
        @(negedge clk);
        check_true(ts_ready === 1'b1, "ts_ready not high after reset");
        check_true(res_valid === 1'b0, "res_valid not low after reset");
        next_cycle();
    endtask

    task automatic start_test();
        err_base = err_cnt;
        res_base = results_seen;
    endtask

    task automatic end_test(input string name, input int exp_results);
        check_true(results_seen - res_base == exp_results, $sformatf(
            "%0d results seen where %0d were due", results_seen - res_base, exp_results));
        check_true(!pending, "results still pending at the end of the test");
        test_cnt++;
        if (err_cnt == err_base) begin
            $display("test %0d %s: pass", test_cnt, name);
        end else begin
            test_fail++;
            $display("test %0d %s: FAIL with %0d errors", test_cnt, name, err_cnt - err_base);
        end
    endtask

    initial begin
        seed       = 59299;
        combin_res = 1'b0;
        ts_valid   = 1'b0;
        ts_data    = '0;
        res_ready  = 1'b0;
        apply_reset();

        start_test();
        run_frame(KIND_RANDOM, 1, 1);
        end_test("random frame, res_ready high", PIXEL_NUM);

        // next frame offered while the previous one drains
        start_test();
        fork
            send_acqs(KIND_RANDOM, 3 * ACQ_NUM, MAX_GAP);
            take_results(3 * PIXEL_NUM, MAX_STALL);
        join
        end_test("gaps and stalls over three frames", 3 * PIXEL_NUM);

        start_test();
        run_frame(KIND_RANDOM, MAX_GAP, MAX_STALL);
        run_frame(KIND_FIXED, MAX_GAP, MAX_STALL);
        end_test("clear between frames", 2 * PIXEL_NUM);

        start_test();
        tie_frame = 1'b1;
        run_frame(KIND_TIE, MAX_GAP, MAX_STALL);
        tie_frame = 1'b0;
        end_test("tie keeps the earlier bin", PIXEL_NUM);

        // two acquisitions, then reset inside the frame
        start_test();
        send_acqs(KIND_RANDOM, 2, MAX_GAP);
        apply_reset();
        run_frame(KIND_RANDOM, MAX_GAP, MAX_STALL);
        end_test("reset in mid frame", PIXEL_NUM);

        start_test();
        run_frame(KIND_RANDOM, MAX_GAP, 1);
        end_test("first-result latency", PIXEL_NUM);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
            test_cnt, test_fail, check_cnt, err_cnt);
        if (err_cnt == 0 && test_fail == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
hist_pkg.sv
acq_sequencer.sv
hist_builder.sv
peak_combiner.sv
hist_peak_top.sv
tb_hist_peak.sv
